// File: logic/discharge_pkg.sv
`default_nettype none

package discharge_pkg;

	// PWM counter, fractional part of the 16.16 level, and period counts
	localparam int cnt_w = 16;
	localparam int frac_w = 16;
	localparam int num_w = 32;
	localparam int level_w = cnt_w + frac_w;

	// Field offsets in the flat profile word, denominator at the bottom
	localparam int prof_den_lsb = 0;
	localparam int prof_n0_lsb = prof_den_lsb + cnt_w;
	localparam int prof_n1_lsb = prof_n0_lsb + cnt_w;
	localparam int prof_cnt0_lsb = prof_n1_lsb + cnt_w;
	localparam int prof_cnt1_lsb = prof_cnt0_lsb + num_w;
	localparam int prof_inc_lsb = prof_cnt1_lsb + num_w;
	localparam int profile_w = prof_inc_lsb + level_w;	// 144 bits

	localparam int fifo_depth = 4;
	localparam int ptr_w = 2;
	localparam int lvl_w = 3;	// Holds 0 to fifo_depth

	// Wishbone word addresses
	localparam int adr_w = 3;
	localparam int dat_w = 32;
	localparam logic [adr_w-1:0] adr_ratio = 3'd0;
	localparam logic [adr_w-1:0] adr_level1 = 3'd1;
	localparam logic [adr_w-1:0] adr_count0 = 3'd2;
	localparam logic [adr_w-1:0] adr_count1 = 3'd3;
	localparam logic [adr_w-1:0] adr_step = 3'd4;
	localparam logic [adr_w-1:0] adr_commit = 3'd5;
	localparam logic [adr_w-1:0] adr_status = 3'd6;

	// Status word: done counter in the low half, then busy, then queue level
	localparam int done_w = 16;
	localparam int stat_busy_bit = 16;
	localparam int stat_lvl_lsb = 24;

	localparam logic default_level = 1'b0;	// Output level while idle
	localparam logic [cnt_w-1:0] reset_den = 16'd4;

	// Controller states
	localparam int st_w = 2;
	localparam logic [st_w-1:0] st_idle = 2'd0;
	localparam logic [st_w-1:0] st_pre = 2'd1;
	localparam logic [st_w-1:0] st_ramp = 2'd2;
	localparam logic [st_w-1:0] st_keep = 2'd3;

	// Register word 0 seen as a plain word or as numerator0 over denominator
	typedef union packed {
		logic [dat_w-1:0] raw;
		struct packed {
			logic [cnt_w-1:0] numerator0;
			logic [cnt_w-1:0] denominator;
		} pair;
	} ratio_word_u;

endpackage

`default_nettype wire

// File: logic/discharge_regs.sv
`timescale 1ns/10ps
`default_nettype none

module discharge_regs (
	input wire clk,
	input wire resetn,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [discharge_pkg::adr_w-1:0] wb_adr,
	input wire [discharge_pkg::dat_w-1:0] wb_dat_w,
	output logic [discharge_pkg::dat_w-1:0] wb_dat_r,
	output logic wb_ack,
	output logic push,
	output logic [discharge_pkg::profile_w-1:0] push_data,
	input wire full,
	input wire [discharge_pkg::lvl_w-1:0] level,
	input wire done,
	input wire busy
);

	discharge_pkg::ratio_word_u ratio_q;	// Numerator0 and denominator
	logic [discharge_pkg::dat_w-1:0] level1_q;	// Numerator1 sits in the low half
	logic [discharge_pkg::dat_w-1:0] count0_q;
	logic [discharge_pkg::dat_w-1:0] count1_q;
	logic [discharge_pkg::dat_w-1:0] step_q;	// 16.16 ramp step
	logic [discharge_pkg::done_w-1:0] done_cnt;
	logic [discharge_pkg::dat_w-1:0] rd_word;
	logic access;
	logic commit;

	// A strobe that has not been acked yet is a new access
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign commit = access && wb_we && (wb_adr == discharge_pkg::adr_commit);
	assign push = commit && !full;	// FIFO takes the profile on the ack edge

	// Ack follows one cycle after the strobe, held off on a commit while full
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= access && !(commit && full);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ratio_q.raw <= {{discharge_pkg::cnt_w{1'b0}}, discharge_pkg::reset_den};
			level1_q <= '0;
			count0_q <= '0;
			count1_q <= '0;
			step_q <= '0;
		end else if (access && wb_we) begin
			case (wb_adr)
				discharge_pkg::adr_ratio: ratio_q.raw <= wb_dat_w;
				discharge_pkg::adr_level1: level1_q <= wb_dat_w;
				discharge_pkg::adr_count0: count0_q <= wb_dat_w;
				discharge_pkg::adr_count1: count1_q <= wb_dat_w;
				discharge_pkg::adr_step: step_q <= wb_dat_w;
				default: ;	// Commit is handled by push, status is read only
			endcase
		end
	end

	// Counts finished profiles, wraps at 16 bits
	always_ff @(posedge clk) begin
		if (!resetn) begin
			done_cnt <= '0;
		end else if (done) begin
			done_cnt <= done_cnt + 1'b1;
		end
	end

	always_comb begin
		rd_word = '0;
		case (wb_adr)
			discharge_pkg::adr_ratio: rd_word = ratio_q.raw;
			discharge_pkg::adr_level1: rd_word = level1_q;
			discharge_pkg::adr_count0: rd_word = count0_q;
			discharge_pkg::adr_count1: rd_word = count1_q;
			discharge_pkg::adr_step: rd_word = step_q;
			discharge_pkg::adr_status: begin
				rd_word[discharge_pkg::done_w-1:0] = done_cnt;
				rd_word[discharge_pkg::stat_busy_bit] = busy;
				rd_word[discharge_pkg::stat_lvl_lsb +: discharge_pkg::lvl_w] = level;
			end
			default: rd_word = '0;	// Commit and unused addresses read as zero
		endcase
	end

	// Read data is valid together with ack
	always_ff @(posedge clk) begin
		if (access && !wb_we) begin
			wb_dat_r <= rd_word;
		end
	end

	// The whole profile as one flat word
	always_comb begin
		push_data[discharge_pkg::prof_den_lsb +: discharge_pkg::cnt_w] =
			ratio_q.pair.denominator;
		push_data[discharge_pkg::prof_n0_lsb +: discharge_pkg::cnt_w] =
			ratio_q.pair.numerator0;
		push_data[discharge_pkg::prof_n1_lsb +: discharge_pkg::cnt_w] =
			level1_q[discharge_pkg::cnt_w-1:0];
		push_data[discharge_pkg::prof_cnt0_lsb +: discharge_pkg::num_w] = count0_q;
		push_data[discharge_pkg::prof_cnt1_lsb +: discharge_pkg::num_w] = count1_q;
		push_data[discharge_pkg::prof_inc_lsb +: discharge_pkg::level_w] = step_q;
	end

endmodule

`default_nettype wire

// File: logic/profile_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module profile_fifo (
	input wire clk,
	input wire resetn,
	input wire push,
	input wire [discharge_pkg::profile_w-1:0] push_data,
	input wire pop,
	output logic [discharge_pkg::profile_w-1:0] pop_data,
	output logic full,
	output logic empty,
	output logic [discharge_pkg::lvl_w-1:0] level
);

	logic [discharge_pkg::profile_w-1:0] mem [discharge_pkg::fifo_depth];
	logic [discharge_pkg::ptr_w-1:0] wr_ptr;
	logic [discharge_pkg::ptr_w-1:0] rd_ptr;
	logic [discharge_pkg::lvl_w-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;	// Overflow is dropped
	assign do_pop = pop && !empty;	// Underflow is dropped

	assign full = (count == discharge_pkg::lvl_w'(discharge_pkg::fifo_depth));
	assign empty = (count == '0);
	assign level = count;

	// Head entry is visible before pop
	assign pop_data = mem[rd_ptr];

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither keep the level
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/discharge_ctl.sv
`timescale 1ns/10ps
`default_nettype none

module discharge_ctl (
	input wire clk,
	input wire resetn,
	input wire empty,
	input wire [discharge_pkg::profile_w-1:0] pop_data,
	output logic pop,
	output logic drive,
	output logic busy,
	output logic done
);

	logic [discharge_pkg::cnt_w-1:0] cnt;	// Counts down, period starts at den - 1
	logic eop_early;	// One cycle ahead of the period end
	logic [discharge_pkg::st_w-1:0] state;
	logic [discharge_pkg::cnt_w-1:0] den_q;
	logic [discharge_pkg::cnt_w-1:0] n1_q;
	logic [discharge_pkg::num_w-1:0] cnt1_q;
	logic [discharge_pkg::level_w-1:0] inc_q;
	logic [discharge_pkg::level_w-1:0] level_q;	// 16.16 off-level
	logic [discharge_pkg::num_w-1:0] period_cnt;
	logic [discharge_pkg::cnt_w-1:0] level_int;
	logic last_period;
	logic at_floor;

	assign level_int = level_q[discharge_pkg::level_w-1:discharge_pkg::frac_w];
	assign last_period = (period_cnt <= discharge_pkg::num_w'(1));
	assign at_floor = (level_int <= n1_q);	// Ramp has reached numerator1

	// Take a new profile only at a period boundary
	assign pop = eop_early && (state == discharge_pkg::st_idle) && !empty;
	assign busy = (state != discharge_pkg::st_idle);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt <= '0;
		end else if (cnt == '0) begin
			cnt <= den_q - 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// Registered from cnt == 2, so it is high while cnt is 1
	always_ff @(posedge clk) begin
		if (!resetn) begin
			eop_early <= 1'b0;
		end else begin
			eop_early <= (cnt == discharge_pkg::cnt_w'(2));
		end
	end

	// Denominator of the running profile, reset value until the first pop
	always_ff @(posedge clk) begin
		if (!resetn) begin
			den_q <= discharge_pkg::reset_den;
		end else if (pop) begin
			den_q <= pop_data[discharge_pkg::prof_den_lsb +: discharge_pkg::cnt_w];
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			n1_q <= pop_data[discharge_pkg::prof_n1_lsb +: discharge_pkg::cnt_w];
			cnt1_q <= pop_data[discharge_pkg::prof_cnt1_lsb +: discharge_pkg::num_w];
			inc_q <= pop_data[discharge_pkg::prof_inc_lsb +: discharge_pkg::level_w];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= discharge_pkg::st_idle;
		end else if (eop_early) begin
			case (state)
				discharge_pkg::st_idle: begin
					if (!empty) begin
						state <= discharge_pkg::st_pre;
					end
				end
				discharge_pkg::st_pre: begin
					if (last_period) begin
						state <= discharge_pkg::st_ramp;
					end
				end
				discharge_pkg::st_ramp: begin
					if (at_floor) begin
						state <= discharge_pkg::st_keep;
					end
				end
				default: begin	// Keep
					if (last_period) begin
						state <= discharge_pkg::st_idle;
					end
				end
			endcase
		end
	end

	// Level and period count change once per period, ahead of the next start
	always_ff @(posedge clk) begin
		if (eop_early) begin
			case (state)
				discharge_pkg::st_idle: begin
					if (pop) begin
						level_q <= {pop_data[discharge_pkg::prof_n0_lsb +: discharge_pkg::cnt_w],
							{discharge_pkg::frac_w{1'b0}}};
						period_cnt <= pop_data[discharge_pkg::prof_cnt0_lsb +: discharge_pkg::num_w];
					end
				end
				discharge_pkg::st_ramp: begin
					if (at_floor) begin
						level_q <= {n1_q, {discharge_pkg::frac_w{1'b0}}};
						period_cnt <= cnt1_q;
					end else if (level_q > inc_q) begin
						level_q <= level_q - inc_q;
					end else begin
						level_q <= '0;	// Clamp instead of wrapping below zero
					end
				end
				default: period_cnt <= period_cnt - 1'b1;	// Pre and keep count down
			endcase
		end
	end

	// Pulses with the fall of busy
	always_ff @(posedge clk) begin
		if (!resetn) begin
			done <= 1'b0;
		end else begin
			done <= eop_early && (state == discharge_pkg::st_keep) && last_period;
		end
	end

	// Active from the period start until the counter meets the level
	always_ff @(posedge clk) begin
		if (!resetn) begin
			drive <= discharge_pkg::default_level;
		end else if (state == discharge_pkg::st_idle) begin
			drive <= discharge_pkg::default_level;
		end else if (cnt == '0) begin
			drive <= (level_int == den_q) ? discharge_pkg::default_level
				: ~discharge_pkg::default_level;
		end else if (cnt == level_int) begin
			drive <= discharge_pkg::default_level;
		end
	end

endmodule

`default_nettype wire

// File: logic/discharge_top.sv
`timescale 1ns/10ps
`default_nettype none

module discharge_top (
	input wire clk,
	input wire resetn,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [discharge_pkg::adr_w-1:0] wb_adr,
	input wire [discharge_pkg::dat_w-1:0] wb_dat_w,
	output wire [discharge_pkg::dat_w-1:0] wb_dat_r,
	output wire wb_ack,
	output wire drive,
	output wire busy
);

	wire push;
	wire [discharge_pkg::profile_w-1:0] push_data;
	wire full;
	wire empty;
	wire [discharge_pkg::lvl_w-1:0] level;
	wire pop;
	wire [discharge_pkg::profile_w-1:0] pop_data;
	wire done;

	// Host side, builds profiles and reports status
	discharge_regs u_regs (
		.clk(clk),
		.resetn(resetn),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.push(push),
		.push_data(push_data),
		.full(full),
		.level(level),
		.done(done),
		.busy(busy)
	);

	profile_fifo u_fifo (
		.clk(clk),
		.resetn(resetn),
		.push(push),
		.push_data(push_data),
		.pop(pop),
		.pop_data(pop_data),
		.full(full),
		.empty(empty),
		.level(level)
	);

	// Runs one profile at a time on the PWM output
	discharge_ctl u_ctl (
		.clk(clk),
		.resetn(resetn),
		.empty(empty),
		.pop_data(pop_data),
		.pop(pop),
		.drive(drive),
		.busy(busy),
		.done(done)
	);

endmodule

`default_nettype wire

// File: test/discharge_chk.sv
`timescale 1ns/10ps
`default_nettype none

module discharge_chk (
	input wire clk,
	input wire resetn,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [discharge_pkg::adr_w-1:0] wb_adr,
	input wire [discharge_pkg::dat_w-1:0] wb_dat_w,
	input wire wb_ack,
	input wire drive,
	input wire busy,
	input wire pop,
	input wire [discharge_pkg::profile_w-1:0] pop_data,
	input wire done,
	input wire full,
	input wire [discharge_pkg::lvl_w-1:0] level
);

	int chk_errors = 0;
	logic [31:0] sh_ratio, sh_lvl1, sh_c0, sh_c1, sh_step;	// Last words written by the host
	logic [31:0] q_ratio [8];
	logic [31:0] q_lvl1 [8];
	logic [31:0] q_c0 [8];
	logic [31:0] q_c1 [8];
	logic [31:0] q_step [8];
	logic [2:0] q_wr, q_rd;
	logic m_dly, m_run, ref_busy, in_rst_q;
	logic [1:0] m_ph;	// 0 pre, 1 ramp, 2 keep
	logic [15:0] m_den, m_n1, m_cyc, m_hi, hi_now, exp_hi;
	logic [31:0] m_lvl, m_left, m_c1, m_inc;
	logic per_end, eop_now, commit_req, wr_take;

	assign hi_now = m_hi + (drive != discharge_pkg::default_level);
	assign exp_hi = m_den - m_lvl[31:16];
	assign per_end = m_run && (m_cyc == m_den - 16'd1);
	assign eop_now = m_run && (m_cyc == m_den - 16'd2);	// Where the FSM changes state
	assign commit_req = wb_cyc && wb_stb && !wb_ack && wb_we
		&& (wb_adr == discharge_pkg::adr_commit);
	// A write takes effect on the edge that raises ack
	assign wr_take = wb_cyc && wb_stb && wb_we && !wb_ack && !(commit_req && full);

	// Profiles as the host committed them, in order
	always_ff @(posedge clk) begin
		if (!resetn) begin
			q_wr <= '0;
			q_rd <= '0;
		end else begin
			if (wr_take) begin
				case (wb_adr)
					discharge_pkg::adr_ratio: sh_ratio <= wb_dat_w;
					discharge_pkg::adr_level1: sh_lvl1 <= wb_dat_w;
					discharge_pkg::adr_count0: sh_c0 <= wb_dat_w;
					discharge_pkg::adr_count1: sh_c1 <= wb_dat_w;
					discharge_pkg::adr_step: sh_step <= wb_dat_w;
					discharge_pkg::adr_commit: begin
						q_ratio[q_wr] <= sh_ratio;
						q_lvl1[q_wr] <= sh_lvl1;
						q_c0[q_wr] <= sh_c0;
						q_c1[q_wr] <= sh_c1;
						q_step[q_wr] <= sh_step;
						q_wr <= q_wr + 3'd1;
					end
					default: ;
				endcase
			end
			if (pop) begin
				q_rd <= q_rd + 3'd1;
			end
		end
	end

	// Reference of the pre, ramp and keep phases, one drive sample per cycle
	always_ff @(posedge clk) begin
		in_rst_q <= !resetn;
		if (!resetn) begin
			m_dly <= 1'b0;
			m_run <= 1'b0;
			ref_busy <= 1'b0;
		end else if (pop) begin
			m_den <= q_ratio[q_rd][15:0];
			m_lvl <= {q_ratio[q_rd][31:16], 16'h0};
			m_n1 <= q_lvl1[q_rd][15:0];
			m_left <= q_c0[q_rd];
			m_c1 <= q_c1[q_rd];
			m_inc <= q_step[q_rd];
			m_ph <= 2'd0;
			m_dly <= 1'b1;
			ref_busy <= 1'b1;
		end else if (m_dly) begin
			m_dly <= 1'b0;	// First period starts after the counter reload
			m_run <= 1'b1;
			m_cyc <= '0;
			m_hi <= '0;
		end else if (m_run) begin
			if (eop_now && m_ph == 2'd2 && m_left <= 32'd1) begin
				ref_busy <= 1'b0;
			end
			if (per_end) begin
				m_cyc <= '0;
				m_hi <= '0;
				if (m_ph == 2'd0) begin
					if (m_left <= 32'd1) m_ph <= 2'd1;
					else m_left <= m_left - 32'd1;
				end else if (m_ph == 2'd1) begin
					if (m_lvl[31:16] <= m_n1) begin
						m_lvl <= {m_n1, 16'h0};
						m_left <= m_c1;
						m_ph <= 2'd2;
					end else begin
						m_lvl <= m_lvl - m_inc;
					end
				end else if (m_left <= 32'd1) begin
					m_run <= 1'b0;
				end else begin
					m_left <= m_left - 32'd1;
				end
			end else begin
				m_cyc <= m_cyc + 16'd1;
				m_hi <= hi_now;
			end
		end
	end

	a_reset: assert property (@(posedge clk) in_rst_q |->
		!wb_ack && !busy && drive == discharge_pkg::default_level)
		else begin $error("Outputs not idle after reset"); chk_errors++; end
	a_ack: assert property (@(posedge clk) disable iff (!resetn)
		wb_cyc && wb_stb && !wb_ack && !(commit_req && full) |=> wb_ack)
		else begin $error("Access not acked one cycle after strobe"); chk_errors++; end
	a_ack_pulse: assert property (@(posedge clk) disable iff (!resetn) wb_ack |=> !wb_ack)
		else begin $error("Ack longer than one cycle"); chk_errors++; end
	a_hold: assert property (@(posedge clk) disable iff (!resetn) commit_req && full |=> !wb_ack)
		else begin $error("Commit acked while queue full"); chk_errors++; end
	a_level: assert property (@(posedge clk) disable iff (!resetn) level <= 3'd4)
		else begin $error("Queue level above four"); chk_errors++; end
	a_order: assert property (@(posedge clk) disable iff (!resetn)
		pop |-> pop_data[discharge_pkg::prof_den_lsb +: discharge_pkg::cnt_w]
			== q_ratio[q_rd][15:0])
		else begin $error("Profile popped out of commit order"); chk_errors++; end
	a_duty: assert property (@(posedge clk) disable iff (!resetn) per_end |-> hi_now == exp_hi)
		else begin $error("Drive high time %0d, expected %0d", hi_now, exp_hi); chk_errors++; end
	a_busy: assert property (@(posedge clk) disable iff (!resetn) busy == ref_busy)
		else begin $error("Busy %0b, expected %0b", busy, ref_busy); chk_errors++; end
	a_done: assert property (@(posedge clk) disable iff (!resetn) $fell(busy) |-> done)
		else begin $error("No done pulse at end of profile"); chk_errors++; end

endmodule

`default_nettype wire

// File: test/discharge_tb.sv
`timescale 1ns/10ps
`default_nettype none

module discharge_tb;

	logic clk = 1'b0;
	logic resetn, wb_cyc, wb_stb, wb_we;
	logic [2:0] wb_adr;
	logic [31:0] wb_dat_w;
	wire [31:0] wb_dat_r;
	wire wb_ack, drive, busy;
	logic [31:0] lfsr = 32'h296b;
	logic [31:0] p_ratio [7];
	logic [31:0] p_lvl1 [7];
	logic [31:0] p_c0 [7];
	logic [31:0] p_c1 [7];
	logic [31:0] p_step [7];
	longint wd_limit = 0;
	int rd_errors = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int err_mark;

	always #20 clk = ~clk;

	discharge_top u_discharge_top (
		.clk(clk), .resetn(resetn), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.drive(drive), .busy(busy)
	);

	bind discharge_top discharge_chk u_chk (
		.clk(clk), .resetn(resetn), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .drive(drive), .busy(busy),
		.pop(pop), .pop_data(pop_data), .done(done), .full(full), .level(level)
	);

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic int total_errors();
		return rd_errors + u_discharge_top.u_chk.chk_errors;
	endfunction

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);	// A full queue holds the commit here
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		@(negedge clk);
		while (!wb_ack) @(negedge clk);
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge clk);
	endtask

	task automatic check_read(input logic [2:0] adr, input logic [31:0] exp,
		input logic [31:0] mask, input string what);
		logic [31:0] got;
		wb_read(adr, got);
		if ((got & mask) != (exp & mask)) begin
			$display("** Error at %0t ns: %s read %h, expected %h", $time, what,
				got & mask, exp & mask);
			rd_errors++;
		end
	endtask

	task automatic write_profile(input int i);
		wb_write(discharge_pkg::adr_ratio, p_ratio[i]);
		wb_write(discharge_pkg::adr_level1, p_lvl1[i]);
		wb_write(discharge_pkg::adr_count0, p_c0[i]);
		wb_write(discharge_pkg::adr_count1, p_c1[i]);
		wb_write(discharge_pkg::adr_step, p_step[i]);
		wb_write(discharge_pkg::adr_commit, 32'h0);
	endtask

	task automatic end_test(input string name);
		if (total_errors() == err_mark) begin
			pass_cnt++;
			$display("Test %s passed at %0t ns", name, $time);
		end else begin
			fail_cnt++;
			$display("Test %s failed at %0t ns", name, $time);
		end
		err_mark = total_errors();
	endtask

	// Ends a run that stops making progress
	initial begin
		wait (wd_limit > 0);
		#(wd_limit);
		$display("Watchdog expired before all profiles finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [31:0] s;
		logic [15:0] den, n0, n1;
		longint periods;
		resetn = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		periods = 0;
		// Distinct denominators 8 to 35, levels ramp down from n0 to n1
		for (int i = 0; i < 7; i++) begin
			den = 16'd8 + 16'(4 * i) + 16'(take_bits(2));
			n0 = 16'(take_bits(6)) % (den + 16'd1);
			n1 = 16'(take_bits(6)) % (n0 + 16'd1);
			p_ratio[i] = {n0, den};
			p_lvl1[i] = {16'h0, n1};
			p_c0[i] = (i == 1) ? 32'd12 + take_bits(2) : 32'd1 + take_bits(2);
			p_c1[i] = 32'd1 + take_bits(2);
			p_step[i] = 32'h4000 + take_bits(14);
			periods += p_c0[i] + p_c1[i] + (longint'(n0) * 65536) / p_step[i] + 2;
		end
		wd_limit = periods * 40 * 40 + 50000;
		err_mark = 0;

		repeat (5) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		end_test("reset");

		for (int a = 0; a <= 4; a++) begin
			s = take_bits(32);
			wb_write(3'(a), s);
			check_read(3'(a), s, 32'hffffffff, "register readback");
		end
		end_test("readback");

		write_profile(0);
		while (!busy) @(negedge clk);
		while (busy) @(negedge clk);
		@(negedge clk);
		check_read(discharge_pkg::adr_status, 32'h0000_0001, 32'h0701_ffff, "status after one");
		end_test("duty and length");

		write_profile(1);
		while (!busy) @(negedge clk);
		for (int i = 2; i < 7; i++) begin
			write_profile(i);
		end
		check_read(discharge_pkg::adr_status, 32'h0401_0000, 32'h0701_0000, "status when full");
		do begin
			wb_read(discharge_pkg::adr_status, s);
		end while (s[16] || s[26:24] != 3'd0);
		check_read(discharge_pkg::adr_status, 32'h0000_0007, 32'h0701_ffff, "status at end");
		end_test("queue order");

		$display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && total_errors() == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
logic/discharge_pkg.sv
logic/discharge_regs.sv
logic/profile_fifo.sv
logic/discharge_ctl.sv
logic/discharge_top.sv
test/discharge_chk.sv
test/discharge_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -f sim.f --top-module discharge_tb -o vsim

out=$(./obj_dir/vsim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"
